/* verilog/kw_pkg.sv */
package kw_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int BLOCK_W = 128;
    localparam int KEY_W   = 256;
    localparam int IV_W    = 96;
    localparam int TAG_W   = 96;

    // ------------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------------

    // Operations carried by a command
    typedef enum logic [1:0] {
        PASS_BLOB,
        UNWRAP_256,
        UNWRAP_512
    } unwrap_op_e;

    typedef enum logic [2:0] {
        SET_KEY,
        ENCRYPT_ZERO,
        STREAM_BLOCKS,
        SEND_LEN,
        SEND_TAG
    } seq_state_e;

    // What the post-processor does with the matching cipher output
    typedef enum logic [2:0] {
        H_PARAM,
        COPY_OUT,
        XOR_OUT,
        MULT_LEN,
        TAG_COMPARE,
        TAG_IGNORE
    } post_op_e;

    // One entry rides the FIFO for every block sent into the cipher
    typedef struct packed {
        post_op_e           op;
        logic [BLOCK_W-1:0] pt;
        logic               eof;
    } fifo_entry_t;

endpackage

/* verilog/ghash_mult.sv */
`timescale 1ns/10ps

module ghash_mult (
    input  logic [kw_pkg::BLOCK_W-1:0] x,
    input  logic [kw_pkg::BLOCK_W-1:0] y,
    output logic [kw_pkg::BLOCK_W-1:0] z
);

    // Reduction constant is 0xE1 followed by zeros in GCM bit order
    localparam logic [kw_pkg::BLOCK_W-1:0] R = {8'hE1, {(kw_pkg::BLOCK_W-8){1'b0}}};

    logic [kw_pkg::BLOCK_W-1:0] v;

    // Bit 0 of a GCM block is the MSB of the vector, hence the reversed walk over x
    always_comb begin
        z = '0;
        v = y;
        for (int i = 0; i < kw_pkg::BLOCK_W; i++) begin
            if (x[kw_pkg::BLOCK_W-1-i]) begin
                z = z ^ v;
            end
            if (v[0]) begin
                v = (v >> 1) ^ R;
            end else begin
                v = v >> 1;
            end
        end
    end

endmodule

/* verilog/block_cipher_stub.sv */
`timescale 1ns/10ps

module block_cipher_stub (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [kw_pkg::KEY_W-1:0]   key_data,
    input  logic                       key_valid,
    output logic                       key_stall,
    input  logic [kw_pkg::BLOCK_W-1:0] blk_data,
    input  logic                       blk_valid,
    input  logic                       blk_last,
    output logic                       blk_stall,
    output logic [kw_pkg::BLOCK_W-1:0] ks_data,
    output logic                       ks_valid,
    input  logic                       ks_stall
);

    logic [kw_pkg::KEY_W-1:0]   key_q;
    logic                       key_held;
    logic [kw_pkg::BLOCK_W-1:0] s1_data;
    logic                       s1_valid;
    logic [kw_pkg::BLOCK_W-1:0] s2_data;
    logic                       s2_valid;
    logic                       s1_ready;
    logic                       s2_ready;
    logic                       blk_take;
    logic                       key_take;
    logic [kw_pkg::BLOCK_W-1:0] mixed;

    // Each stage moves on when the one after it is empty or draining
    assign s2_ready  = ~s2_valid | ~ks_stall;
    assign s1_ready  = ~s1_valid | s2_ready;
    assign blk_stall = ~s1_ready;
    assign blk_take  = blk_valid & s1_ready;

    // A new key waits for the last block of the previous command to drain
    assign key_stall = key_held | s1_valid | s2_valid;
    assign key_take  = key_valid & ~key_stall;

    // Rotate left by 13, then fold in both key halves
    assign mixed = {blk_data[kw_pkg::BLOCK_W-14:0], blk_data[kw_pkg::BLOCK_W-1:kw_pkg::BLOCK_W-13]}
                 ^ key_q[kw_pkg::KEY_W-1:kw_pkg::BLOCK_W]
                 ^ key_q[kw_pkg::BLOCK_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_held <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (key_take) begin
                key_held <= 1'b1;
            end else if (blk_take && blk_last) begin
                key_held <= 1'b0;
            end
            if (s1_ready) begin
                s1_valid <= blk_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_take) begin
            key_q <= key_data;
        end
        if (blk_take) begin
            s1_data <= mixed;
        end
        if (s2_ready && s1_valid) begin
            s2_data <= s1_data;
        end
    end

    assign ks_data  = s2_data;
    assign ks_valid = s2_valid;

endmodule

/* verilog/bypass_fifo.sv */
`timescale 1ns/10ps

module bypass_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_valid,
    output logic             wr_stall,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    input  logic             rd_pop
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_stall = (count == (AW+1)'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign wr_fire = wr_valid & ~wr_stall;
    assign rd_fire = rd_pop & rd_valid;

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* verilog/gcm_sequencer.sv */
`timescale 1ns/10ps

module gcm_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  kw_pkg::unwrap_op_e         cmd_op,
    input  logic [kw_pkg::KEY_W-1:0]   cmd_key,
    input  logic [kw_pkg::IV_W-1:0]    cmd_iv,
    output logic                       cmd_ack,
    input  logic                       in_valid,
    input  logic                       in_eof,
    input  logic [kw_pkg::BLOCK_W-1:0] in_data,
    output logic                       in_stall,
    input  logic                       tag_valid,
    input  logic [kw_pkg::TAG_W-1:0]   tag_data,
    output logic                       tag_ack,
    output logic [kw_pkg::KEY_W-1:0]   key_data,
    output logic                       key_valid,
    input  logic                       key_stall,
    output logic [kw_pkg::BLOCK_W-1:0] blk_data,
    output logic                       blk_valid,
    output logic                       blk_last,
    input  logic                       blk_stall,
    output kw_pkg::fifo_entry_t        entry,
    output logic                       entry_valid,
    input  logic                       entry_stall
);

    kw_pkg::seq_state_e         state_q;
    kw_pkg::seq_state_e         state_d;
    logic [kw_pkg::BLOCK_W-1:0] counter_q;
    logic [1:0]                 beat_q;
    logic                       issue_stall;
    logic                       beat_take;
    kw_pkg::post_op_e           beat_op;
    logic [kw_pkg::BLOCK_W-1:0] beat_pt;
    logic [kw_pkg::BLOCK_W-1:0] len_word;

    // Cipher and FIFO are written together so their outputs stay paired
    assign issue_stall = blk_stall | entry_stall;
    assign beat_take   = (state_q == kw_pkg::STREAM_BLOCKS) & in_valid & ~issue_stall;

    // Post-op of a payload beat by opcode and position in the blob
    always_comb begin
        beat_op = kw_pkg::XOR_OUT;
        beat_pt = in_data;
        case (cmd_op)
            kw_pkg::PASS_BLOB: beat_op = kw_pkg::COPY_OUT;
            kw_pkg::UNWRAP_256: begin
                // The first half of a 256-bit unwrap leaves as zero
                if (!beat_q[1]) begin
                    beat_op = kw_pkg::COPY_OUT;
                    beat_pt = '0;
                end
            end
            default: beat_op = kw_pkg::XOR_OUT;
        endcase
    end

    // Bit length of the decrypted payload for the closing GHASH block
    always_comb begin
        case (cmd_op)
            kw_pkg::UNWRAP_256: len_word = {{(kw_pkg::BLOCK_W-16){1'b0}}, 16'd256};
            kw_pkg::UNWRAP_512: len_word = {{(kw_pkg::BLOCK_W-16){1'b0}}, 16'd512};
            default:            len_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= kw_pkg::SET_KEY;
            beat_q  <= 2'd0;
        end else begin
            state_q <= state_d;
            if (beat_take) begin
                beat_q <= in_eof ? 2'd0 : beat_q + 2'd1;
            end
        end
    end

    // Counter block starts at {iv, 2}; only the low 32 bits count
    always_ff @(posedge clk) begin
        if (state_q == kw_pkg::SET_KEY) begin
            counter_q <= {cmd_iv, 32'd2};
        end else if (beat_take && beat_op == kw_pkg::XOR_OUT) begin
            counter_q <= {counter_q[kw_pkg::BLOCK_W-1:32], counter_q[31:0] + 32'd1};
        end
    end

    // ------------------------------------------------------------------------
    // Command FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_d     = state_q;
        key_data    = cmd_key;
        key_valid   = 1'b0;
        blk_data    = '0;
        blk_valid   = 1'b0;
        blk_last    = 1'b0;
        entry       = '0;
        entry_valid = 1'b0;
        cmd_ack     = 1'b0;
        tag_ack     = 1'b0;
        in_stall    = 1'b1;
        case (state_q)
            kw_pkg::SET_KEY: begin
                if (cmd_valid && !key_stall) begin
                    key_valid = 1'b1;
                    state_d   = kw_pkg::ENCRYPT_ZERO;
                end
            end
            kw_pkg::ENCRYPT_ZERO: begin
                if (!issue_stall) begin
                    blk_valid   = 1'b1;
                    entry.op    = kw_pkg::H_PARAM;
                    entry_valid = 1'b1;
                    state_d     = kw_pkg::STREAM_BLOCKS;
                end
            end
            kw_pkg::STREAM_BLOCKS: begin
                in_stall = issue_stall;
                if (beat_take) begin
                    blk_data    = counter_q;
                    blk_valid   = 1'b1;
                    entry.op    = beat_op;
                    entry.pt    = beat_pt;
                    entry.eof   = in_eof;
                    entry_valid = 1'b1;
                    if (in_eof) begin
                        state_d = kw_pkg::SEND_LEN;
                    end
                end
            end
            kw_pkg::SEND_LEN: begin
                if (!issue_stall) begin
                    blk_data    = {cmd_iv, 32'd1};
                    blk_valid   = 1'b1;
                    entry.op    = kw_pkg::MULT_LEN;
                    entry.pt    = len_word;
                    entry_valid = 1'b1;
                    state_d     = kw_pkg::SEND_TAG;
                end
            end
            kw_pkg::SEND_TAG: begin
                if (tag_valid && !issue_stall) begin
                    blk_valid   = 1'b1;
                    blk_last    = 1'b1;
                    entry.op    = (cmd_op == kw_pkg::PASS_BLOB) ? kw_pkg::TAG_IGNORE
                                                                : kw_pkg::TAG_COMPARE;
                    entry.pt    = {tag_data, {(kw_pkg::BLOCK_W-kw_pkg::TAG_W){1'b0}}};
                    entry_valid = 1'b1;
                    tag_ack     = 1'b1;
                    cmd_ack     = 1'b1;
                    state_d     = kw_pkg::SET_KEY;
                end
            end
            default: state_d = kw_pkg::SET_KEY;
        endcase
    end

endmodule

/* verilog/gcm_post.sv */
`timescale 1ns/10ps

module gcm_post (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [kw_pkg::BLOCK_W-1:0] ks_data,
    input  logic                       ks_valid,
    output logic                       ks_stall,
    input  kw_pkg::fifo_entry_t        head,
    input  logic                       head_valid,
    output logic                       head_pop,
    output logic                       out_valid,
    output logic                       out_eof,
    output logic [kw_pkg::BLOCK_W-1:0] out_data,
    input  logic                       out_stall,
    output logic                       status_valid,
    output logic                       status_mismatch,
    input  logic                       status_stall
);

    logic [kw_pkg::BLOCK_W-1:0] h_q;
    logic [kw_pkg::BLOCK_W-1:0] acc_q;
    logic [kw_pkg::BLOCK_W-1:0] mult_x;
    logic [kw_pkg::BLOCK_W-1:0] mult_z;
    logic                       active;
    logic                       is_data;
    logic                       is_tag;
    logic                       consume;

    assign active  = ks_valid & head_valid;
    assign is_data = (head.op == kw_pkg::COPY_OUT) | (head.op == kw_pkg::XOR_OUT);
    assign is_tag  = (head.op == kw_pkg::TAG_COMPARE) | (head.op == kw_pkg::TAG_IGNORE);

    // Only ops that drive an output stream can be held back
    assign ks_stall = is_data ? out_stall : (is_tag ? status_stall : 1'b0);
    assign consume  = active & ~ks_stall;
    assign head_pop = consume;

    assign out_valid = active & is_data;
    assign out_eof   = head.eof;
    assign out_data  = (head.op == kw_pkg::XOR_OUT) ? (head.pt ^ ks_data) : head.pt;

    // Compare the top TAG_W bits of the hash against the supplied tag
    assign status_valid    = active & is_tag;
    assign status_mismatch = (head.op == kw_pkg::TAG_COMPARE)
                           & (acc_q[kw_pkg::BLOCK_W-1 -: kw_pkg::TAG_W]
                              != head.pt[kw_pkg::BLOCK_W-1 -: kw_pkg::TAG_W]);

    assign mult_x = head.pt ^ acc_q;

    ghash_mult ghash_mult_inst (
        .x (mult_x),
        .y (h_q),
        .z (mult_z)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_q   <= '0;
            acc_q <= '0;
        end else if (consume) begin
            case (head.op)
                kw_pkg::H_PARAM: begin
                    h_q   <= ks_data;
                    acc_q <= '0;
                end
                kw_pkg::XOR_OUT:  acc_q <= mult_z;
                // Length block closes the hash with E(iv, 1)
                kw_pkg::MULT_LEN: acc_q <= mult_z ^ ks_data;
                default:          acc_q <= acc_q;
            endcase
        end
    end

endmodule

/* verilog/gcm_unwrap_top.sv */
`timescale 1ns/10ps

module gcm_unwrap_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  kw_pkg::unwrap_op_e         cmd_op,
    input  logic [kw_pkg::KEY_W-1:0]   cmd_key,
    input  logic [kw_pkg::IV_W-1:0]    cmd_iv,
    output logic                       cmd_ack,
    input  logic                       in_valid,
    input  logic                       in_eof,
    input  logic [kw_pkg::BLOCK_W-1:0] in_data,
    output logic                       in_stall,
    input  logic                       tag_valid,
    input  logic [kw_pkg::TAG_W-1:0]   tag_data,
    output logic                       tag_ack,
    output logic                       out_valid,
    output logic                       out_eof,
    output logic [kw_pkg::BLOCK_W-1:0] out_data,
    input  logic                       out_stall,
    output logic                       status_valid,
    output logic                       status_mismatch,
    input  logic                       status_stall,
    output logic                       tag_fail_int
);

    logic [kw_pkg::KEY_W-1:0]   key_data;
    logic                       key_valid;
    logic                       key_stall;
    logic [kw_pkg::BLOCK_W-1:0] blk_data;
    logic                       blk_valid;
    logic                       blk_last;
    logic                       blk_stall;
    kw_pkg::fifo_entry_t        entry;
    logic                       entry_valid;
    logic                       entry_stall;
    logic [kw_pkg::BLOCK_W-1:0] ks_data;
    logic                       ks_valid;
    logic                       ks_stall;
    kw_pkg::fifo_entry_t        head;
    logic                       head_valid;
    logic                       head_pop;

    gcm_sequencer gcm_sequencer_inst (.*);

    block_cipher_stub block_cipher_stub_inst (.*);

    // The FIFO holds the post-op of every block while the cipher works on it
    bypass_fifo #(
        .WIDTH ($bits(kw_pkg::fifo_entry_t)),
        .DEPTH (FIFO_DEPTH)
    ) bypass_fifo_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_data  (entry),
        .wr_valid (entry_valid),
        .wr_stall (entry_stall),
        .rd_data  (head),
        .rd_valid (head_valid),
        .rd_pop   (head_pop)
    );

    gcm_post gcm_post_inst (.*);

    assign tag_fail_int = status_valid & status_mismatch;

endmodule

/* test/gcm_model.svh */
`ifndef GCM_MODEL_SVH
`define GCM_MODEL_SVH

// Stand-in cipher rotates the block left by 13 and folds in both key halves
function automatic logic [kw_pkg::BLOCK_W-1:0] cipher_model(
    input logic [kw_pkg::KEY_W-1:0]   key,
    input logic [kw_pkg::BLOCK_W-1:0] blk
);
    logic [kw_pkg::BLOCK_W-1:0] rot;
    rot = (blk << 13) | (blk >> (kw_pkg::BLOCK_W - 13));
    return rot ^ key[kw_pkg::KEY_W-1:kw_pkg::BLOCK_W] ^ key[kw_pkg::BLOCK_W-1:0];
endfunction

// Multiply by the field generator in the reflected bit order of GCM
function automatic logic [kw_pkg::BLOCK_W-1:0] times_alpha(
    input logic [kw_pkg::BLOCK_W-1:0] v
);
    if (v[0]) begin
        return (v >> 1) ^ {8'he1, 120'd0};
    end
    return v >> 1;
endfunction

// Horner evaluation from the degree-127 coefficient (vector bit 0) downwards
function automatic logic [kw_pkg::BLOCK_W-1:0] gf_mult_model(
    input logic [kw_pkg::BLOCK_W-1:0] x,
    input logic [kw_pkg::BLOCK_W-1:0] y
);
    logic [kw_pkg::BLOCK_W-1:0] z;
    z = '0;
    for (int j = 0; j < kw_pkg::BLOCK_W; j++) begin
        z = times_alpha(z);
        if (x[j]) begin
            z = z ^ y;
        end
    end
    return z;
endfunction

function automatic logic beat_is_decrypted(input kw_pkg::unwrap_op_e op, input int b);
    return (op == kw_pkg::UNWRAP_512) || (op == kw_pkg::UNWRAP_256 && b >= 2);
endfunction

// Output beat for payload beat b of a command
function automatic logic [kw_pkg::BLOCK_W-1:0] expected_beat(
    input kw_pkg::unwrap_op_e         op,
    input logic [kw_pkg::KEY_W-1:0]   key,
    input logic [kw_pkg::IV_W-1:0]    iv,
    input int                         b,
    input logic [kw_pkg::BLOCK_W-1:0] data
);
    int ctr;
    if (op == kw_pkg::PASS_BLOB) begin
        return data;
    end
    if (!beat_is_decrypted(op, b)) begin
        return '0;
    end
    // The first decrypted beat uses counter 2 and each later one the next value
    ctr = 2;
    for (int i = 0; i < b; i++) begin
        if (beat_is_decrypted(op, i)) begin
            ctr = ctr + 1;
        end
    end
    return data ^ cipher_model(key, {iv, 32'(ctr)});
endfunction

// Final GHASH value closed with the length block and E(iv, 1)
function automatic logic [kw_pkg::BLOCK_W-1:0] expected_tag(
    input kw_pkg::unwrap_op_e               op,
    input logic [kw_pkg::KEY_W-1:0]         key,
    input logic [kw_pkg::IV_W-1:0]          iv,
    input logic [3:0][kw_pkg::BLOCK_W-1:0]  beats
);
    logic [kw_pkg::BLOCK_W-1:0] h;
    logic [kw_pkg::BLOCK_W-1:0] acc;
    logic [kw_pkg::BLOCK_W-1:0] len;
    h   = cipher_model(key, '0);
    acc = '0;
    for (int b = 0; b < 4; b++) begin
        if (beat_is_decrypted(op, b)) begin
            acc = gf_mult_model(acc ^ beats[b], h);
        end
    end
    case (op)
        kw_pkg::UNWRAP_256: len = 128'd256;
        kw_pkg::UNWRAP_512: len = 128'd512;
        default:            len = '0;
    endcase
    return gf_mult_model(acc ^ len, h) ^ cipher_model(key, {iv, 32'd1});
endfunction

`endif

/* test/tb_gcm_unwrap.sv */
`timescale 1ns/10ps

module tb_gcm_unwrap;

    localparam int NUM_ROWS   = 6;
    localparam int BEATS      = 4;
    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;

    logic                       clk;
    logic                       rst_n;
    logic                       cmd_valid;
    kw_pkg::unwrap_op_e         cmd_op;
    logic [kw_pkg::KEY_W-1:0]   cmd_key;
    logic [kw_pkg::IV_W-1:0]    cmd_iv;
    logic                       cmd_ack;
    logic                       in_valid;
    logic                       in_eof;
    logic [kw_pkg::BLOCK_W-1:0] in_data;
    logic                       in_stall;
    logic                       tag_valid;
    logic [kw_pkg::TAG_W-1:0]   tag_data;
    logic                       tag_ack;
    logic                       out_valid;
    logic                       out_eof;
    logic [kw_pkg::BLOCK_W-1:0] out_data;
    logic                       out_stall;
    logic                       status_valid;
    logic                       status_mismatch;
    logic                       status_stall;
    logic                       tag_fail_int;

    `include "gcm_model.svh"

    // Stimulus table with one entry per command
    kw_pkg::unwrap_op_e                    row_op    [NUM_ROWS];
    logic [kw_pkg::KEY_W-1:0]              row_key   [NUM_ROWS];
    logic [kw_pkg::IV_W-1:0]               row_iv    [NUM_ROWS];
    logic [BEATS-1:0][kw_pkg::BLOCK_W-1:0] row_beats [NUM_ROWS];
    logic                                  row_bad   [NUM_ROWS];
    int unsigned                           row_stall [NUM_ROWS];

    logic [kw_pkg::BLOCK_W-1:0] exp_data     [$];
    logic                       exp_eof      [$];
    logic                       exp_mismatch [$];
    int unsigned                stall_pct;
    int                         out_seen;
    int                         status_seen;

    gcm_unwrap_top #(
        .FIFO_DEPTH (16)
    ) gcm_unwrap_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Quiet interface while no command has been given
    task automatic check_idle();
        check_value("in_stall", 128'(in_stall), 128'd1);
        check_value("out_valid", 128'(out_valid), 128'd0);
        check_value("status_valid", 128'(status_valid), 128'd0);
        check_value("cmd_ack", 128'(cmd_ack), 128'd0);
        check_value("tag_ack", 128'(tag_ack), 128'd0);
        check_value("tag_fail_int", 128'(tag_fail_int), 128'd0);
    endtask

    task automatic check_output_beat();
        logic [kw_pkg::BLOCK_W-1:0] want_data;
        logic                       want_eof;
        if (exp_data.size() == 0) begin
            abort_run("An output beat arrived when no beat was expected");
        end else begin
            want_data = exp_data.pop_front();
            want_eof  = exp_eof.pop_front();
            check_value("out_data", out_data, want_data);
            check_value("out_eof", 128'(out_eof), 128'(want_eof));
            out_seen = out_seen + 1;
        end
    endtask

    task automatic check_status();
        logic want;
        if (exp_mismatch.size() == 0) begin
            abort_run("A status arrived when no command was pending");
        end else begin
            want = exp_mismatch.pop_front();
            check_value("status_mismatch", 128'(status_mismatch), 128'(want));
            check_value("tag_fail_int", 128'(tag_fail_int), 128'(want));
            status_seen = status_seen + 1;
        end
    endtask

    // Outputs are sampled half a cycle before the edge that transfers them
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (out_valid && !out_stall) begin
                    check_output_beat();
                end
                if (status_valid && !status_stall) begin
                    check_status();
                end else if (!status_valid) begin
                    check_value("tag_fail_int", 128'(tag_fail_int), 128'd0);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    task automatic set_row(
        input int                         r,
        input kw_pkg::unwrap_op_e         op,
        input logic [kw_pkg::KEY_W-1:0]   key,
        input logic [kw_pkg::IV_W-1:0]    iv,
        input logic [kw_pkg::BLOCK_W-1:0] b0,
        input logic [kw_pkg::BLOCK_W-1:0] b1,
        input logic [kw_pkg::BLOCK_W-1:0] b2,
        input logic [kw_pkg::BLOCK_W-1:0] b3,
        input logic                       bad,
        input int unsigned                pct
    );
        row_op[r]    = op;
        row_key[r]   = key;
        row_iv[r]    = iv;
        row_beats[r] = {b3, b2, b1, b0};
        row_bad[r]   = bad;
        row_stall[r] = pct;
    endtask

    task automatic load_table();
        set_row(0, kw_pkg::PASS_BLOB,
            256'h00010203_04050607_08090a0b_0c0d0e0f_10111213_14151617_18191a1b_1c1d1e1f,
            96'hcafebabe_facedbad_decaf888,
            128'hd9313225_f88406e5_a55909c5_aff5269a, 128'h86a7a953_1534f7da_2e4c303d_8a318a72,
            128'h1c3c0c95_956809d5_3dbe4a56_33b3a8f3, 128'h0f5e1d2c_3b4a5968_77869504_a3b2c1d0,
            1'b0, 0);
        set_row(1, kw_pkg::UNWRAP_256,
            256'h603deb10_15ca71be_2b73aef0_857d7781_1f352c07_3b6108d7_2d9810a3_0914dff4,
            96'h9313225d_f88406e5_55909c5a,
            128'h42831ec2_21777424_4b7221b7_84d0d49c, 128'he3aa212f_2c02a4e0_35c17e23_29aca12e,
            128'h21d514b2_5466931c_7d8f6a5a_ac84aa05, 128'h1ba30b39_6a0aac97_3d58e091_473f5985,
            1'b0, 0);
        set_row(2, kw_pkg::UNWRAP_512,
            256'h8e73b0f7_da0e6452_c810f32b_809079e5_62f8ead2_522c6b7b_feffe992_8665731c,
            96'h0a1b2c3d_4e5f6071_8293a4b5,
            128'h522dc1f0_99567d07_f47f37a3_2a84427d, 128'h643a8cdc_bfe5c0c9_7598a2bd_2555d1aa,
            128'h8cb08e48_590dbb3d_a7b08b10_56828838, 128'hc5f61e63_93ba7a0a_bcc9f662_898015ad,
            1'b0, 0);
        set_row(3, kw_pkg::UNWRAP_256,
            256'hc47b0294_dbbbee0f_ec4757f2_2ffeee35_87ca4730_c3d33b69_1df38bab_076bc558,
            96'hffffffff_00000000_12345678,
            128'h46aa0c1b_7f3d8e90_11223344_deadbeef, 128'h0badf00d_5a5aa5a5_c3c33c3c_01234567,
            128'h89abcdef_fedcba98_76543210_13579bdf, 128'h2468ace0_f0e1d2c3_b4a59687_78695a4b,
            1'b1, 30);
        set_row(4, kw_pkg::UNWRAP_512,
            256'h4c973dbc_7364621a_2f9e7b05_1f5c1a2e_3b7a6d88_91c4e2f0_5a6b7c8d_9eafb0c1,
            96'h5c5d5e5f_60616263_64656667,
            128'h3c2d1e0f_a9b8c7d6_e5f40312_21304f5e, 128'h6d7c8b9a_a8b7c6d5_e4f30211_2f3e4d5c,
            128'h7766_5544_3322_1100_ffee_ddcc_bbaa_9988, 128'h01020408_10204080_fefdfbf7_efdfbf7f,
            1'b0, 50);
        set_row(5, kw_pkg::UNWRAP_512,
            256'h2b7e1516_28aed2a6_abf71588_09cf4f3c_a0fafe17_88542cb1_23a33939_2a6c7605,
            96'h11223344_55667788_99aabbcc,
            128'h6bc1bee2_2e409f96_e93d7e11_7393172a, 128'hae2d8a57_1e03ac9c_9eb76fac_45af8e51,
            128'h30c81c46_a35ce411_e5fbc119_1a0a52ef, 128'hf69f2445_df4f9b17_ad2b417b_e66c3710,
            1'b1, 40);
    endtask

    // Queue the expected results of a row, then run its command, beats and tag
    task automatic drive_row(input int r);
        logic [kw_pkg::BLOCK_W-1:0] full_tag;
        logic [kw_pkg::TAG_W-1:0]   tag;
        for (int b = 0; b < BEATS; b++) begin
            exp_data.push_back(expected_beat(row_op[r], row_key[r], row_iv[r], b,
                                             row_beats[r][b]));
            exp_eof.push_back(b == BEATS - 1);
        end
        full_tag = expected_tag(row_op[r], row_key[r], row_iv[r], row_beats[r]);
        tag      = full_tag[kw_pkg::BLOCK_W-1 -: kw_pkg::TAG_W];
        if (row_bad[r]) begin
            tag[0] = ~tag[0];
        end
        exp_mismatch.push_back((row_op[r] != kw_pkg::PASS_BLOB)
                               && (tag != full_tag[kw_pkg::BLOCK_W-1 -: kw_pkg::TAG_W]));
        stall_pct = row_stall[r];

        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= row_op[r];
        cmd_key   <= row_key[r];
        cmd_iv    <= row_iv[r];
        for (int b = 0; b < BEATS; b++) begin
            in_valid <= 1'b1;
            in_data  <= row_beats[r][b];
            in_eof   <= (b == BEATS - 1);
            @(negedge clk);
            while (in_stall) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        in_valid  <= 1'b0;
        in_eof    <= 1'b0;
        tag_valid <= 1'b1;
        tag_data  <= tag;
        @(negedge clk);
        while (!tag_ack) begin
            @(negedge clk);
        end
        check_value("cmd_ack", 128'(cmd_ack), 128'd1);
        @(posedge clk);
        tag_valid <= 1'b0;
        cmd_valid <= 1'b0;
    endtask

    // Random back-pressure on both output streams
    initial begin
        void'($urandom(54));
        out_stall    = 1'b0;
        status_stall = 1'b0;
        forever begin
            @(posedge clk);
            out_stall    <= ($urandom % 100) < stall_pct;
            status_stall <= ($urandom % 100) < stall_pct;
        end
    end

    initial begin
        #(NUM_ROWS * 200 * CLK_PERIOD);
        abort_run("Timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_op      = kw_pkg::PASS_BLOB;
        cmd_key     = '0;
        cmd_iv      = '0;
        in_valid    = 1'b0;
        in_eof      = 1'b0;
        in_data     = '0;
        tag_valid   = 1'b0;
        tag_data    = '0;
        stall_pct   = 0;
        out_seen    = 0;
        status_seen = 0;
        load_table();

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            drive_row(r);
        end

        // Let the last status through, then leave room for any stray beat
        wait (status_seen == NUM_ROWS);
        repeat (20) @(posedge clk);
        if (out_seen == NUM_ROWS * BEATS && exp_data.size() == 0
            && exp_mismatch.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("The number of output beats or statuses differs from the commands sent");
        end
    end

endmodule

/* gcm_unwrap.f */
+incdir+test
verilog/kw_pkg.sv
verilog/ghash_mult.sv
verilog/block_cipher_stub.sv
verilog/bypass_fifo.sv
verilog/gcm_sequencer.sv
verilog/gcm_post.sv
verilog/gcm_unwrap_top.sv
test/tb_gcm_unwrap.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_gcm_unwrap -f gcm_unwrap.f \
        -o sim_gcm_unwrap &&
    { ./obj_dir/sim_gcm_unwrap > sim.log 2>&1; cat sim.log; } &&
    grep -q '\*\*\* PASSED \*\*\*' sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
